// ==== rtl/rp_defines.svh ====
////////////////////////////////////////////////////////////
// analog core shared widths, fixed-point scale and
// register reset values
////////////////////////////////////////////////////////////

`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// ADC and DAC channel count
`define RP_CHN       2

// ADC pin bus, two reserved low bits below the sample
`define RP_ADC_W     16
`define RP_SMP_W     14

// calibration gain, 13 fraction bits
`define RP_MUL_W     16
`define RP_MUL_SHIFT 13
// unity gain
`define RP_MUL_RST   16'sh2000

// debounce hold-off counter
`define RP_LEN_W     20
// 0.5 ms at 125 MHz
`define RP_LEN_RST   20'd62500

// register bus
`define RP_ADDR_W    4
`define RP_DATA_W    32

`endif

// ==== rtl/rp_pkg.sv ====
////////////////////////////////////////////////////////////
// analog core types: samples, calibration values, register
// map and debounce states
////////////////////////////////////////////////////////////

`default_nettype none

`include "rp_defines.svh"

package rp_pkg;

  // signed sample, ADC and DAC side alike
  typedef logic signed [`RP_SMP_W-1:0] smp_t;
  // calibration gain and offset
  typedef logic signed [`RP_MUL_W-1:0] mul_t;
  typedef logic signed [`RP_SMP_W-1:0] sum_t;
  // hold-off length in clock cycles
  typedef logic        [`RP_LEN_W-1:0] len_t;

  // register map
  typedef enum logic [`RP_ADDR_W-1:0] {
    REG_MUX      = 4'd0,  // [1:0] loopback, [3:2] host source
    REG_DEB_LEN  = 4'd1,
    REG_ADC_MUL0 = 4'd2,
    REG_ADC_SUM0 = 4'd3,
    REG_ADC_MUL1 = 4'd4,
    REG_ADC_SUM1 = 4'd5,
    REG_DAC_MUL0 = 4'd6,
    REG_DAC_SUM0 = 4'd7,
    REG_DAC_MUL1 = 4'd8,
    REG_DAC_SUM1 = 4'd9
  } reg_addr_e;

  // debounce FSM
  typedef enum logic {
    DEB_IDLE = 1'b0,
    DEB_HOLD = 1'b1
  } deb_state_e;

endpackage : rp_pkg

`default_nettype wire

// ==== rtl/rp_regs.sv ====
////////////////////////////////////////////////////////////
// control registers for loopback/source muxes, per-channel
// calibration and debounce length, strobe access
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_regs (
  input  logic                        adc_clk,
  input  logic                        top_rst,
  // register access strobes
  input  logic                        reg_wr_i,
  input  logic                        reg_rd_i,
  input  logic [`RP_ADDR_W-1:0]       reg_addr_i,
  input  logic [`RP_DATA_W-1:0]       reg_wdata_i,
  output logic [`RP_DATA_W-1:0]       reg_rdata_o,
  output logic                        reg_ack_o,
  // mux selects per channel
  output logic [`RP_CHN-1:0]          mux_loop_o,
  output logic [`RP_CHN-1:0]          mux_host_o,
  // calibration per channel
  output rp_pkg::mul_t [`RP_CHN-1:0]  adc_mul_o,
  output rp_pkg::sum_t [`RP_CHN-1:0]  adc_sum_o,
  output rp_pkg::mul_t [`RP_CHN-1:0]  dac_mul_o,
  output rp_pkg::sum_t [`RP_CHN-1:0]  dac_sum_o,
  // debounce
  output rp_pkg::len_t                deb_len_o
);

  import rp_pkg::*;

  localparam int DW = `RP_DATA_W;

  reg_addr_e     addr;
  logic [DW-1:0] rd_mux;

  // sign extension for readback
  function automatic logic [DW-1:0] mul_rd(input mul_t val);
    return DW'(val);
  endfunction

  function automatic logic [DW-1:0] sum_rd(input sum_t val);
    return DW'(val);
  endfunction

  assign addr = reg_addr_e'(reg_addr_i);

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      // no loopback, generator source
      mux_loop_o <= '0;
      mux_host_o <= '0;
      deb_len_o  <= `RP_LEN_RST;
      // unity gain, zero offset
      adc_mul_o  <= {`RP_CHN{`RP_MUL_RST}};
      dac_mul_o  <= {`RP_CHN{`RP_MUL_RST}};
      adc_sum_o  <= '0;
      dac_sum_o  <= '0;
    end else if (reg_wr_i) begin
      case (addr)
        REG_MUX: begin
          mux_loop_o <= reg_wdata_i[`RP_CHN-1:0];
          mux_host_o <= reg_wdata_i[2*`RP_CHN-1:`RP_CHN];
        end
        REG_DEB_LEN:  deb_len_o    <= reg_wdata_i[`RP_LEN_W-1:0];
        REG_ADC_MUL0: adc_mul_o[0] <= reg_wdata_i[`RP_MUL_W-1:0];
        REG_ADC_SUM0: adc_sum_o[0] <= reg_wdata_i[`RP_SMP_W-1:0];
        REG_ADC_MUL1: adc_mul_o[1] <= reg_wdata_i[`RP_MUL_W-1:0];
        REG_ADC_SUM1: adc_sum_o[1] <= reg_wdata_i[`RP_SMP_W-1:0];
        REG_DAC_MUL0: dac_mul_o[0] <= reg_wdata_i[`RP_MUL_W-1:0];
        REG_DAC_SUM0: dac_sum_o[0] <= reg_wdata_i[`RP_SMP_W-1:0];
        REG_DAC_MUL1: dac_mul_o[1] <= reg_wdata_i[`RP_MUL_W-1:0];
        REG_DAC_SUM1: dac_sum_o[1] <= reg_wdata_i[`RP_SMP_W-1:0];
        // unmapped, write dropped
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (addr)
      REG_MUX:      rd_mux = DW'({mux_host_o, mux_loop_o});
      REG_DEB_LEN:  rd_mux = DW'(deb_len_o);
      REG_ADC_MUL0: rd_mux = mul_rd(adc_mul_o[0]);
      REG_ADC_SUM0: rd_mux = sum_rd(adc_sum_o[0]);
      REG_ADC_MUL1: rd_mux = mul_rd(adc_mul_o[1]);
      REG_ADC_SUM1: rd_mux = sum_rd(adc_sum_o[1]);
      REG_DAC_MUL0: rd_mux = mul_rd(dac_mul_o[0]);
      REG_DAC_SUM0: rd_mux = sum_rd(dac_sum_o[0]);
      REG_DAC_MUL1: rd_mux = mul_rd(dac_mul_o[1]);
      REG_DAC_SUM1: rd_mux = sum_rd(dac_sum_o[1]);
      // unmapped reads zero
      default:      rd_mux = '0;
    endcase
  end

  // data and ack one cycle after the strobe
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      reg_ack_o   <= 1'b0;
      reg_rdata_o <= '0;
    end else begin
      reg_ack_o <= reg_rd_i;
      if (reg_rd_i) begin
        reg_rdata_o <= rd_mux;
      end
    end
  end

endmodule : rp_regs

`default_nettype wire

// ==== rtl/rp_linear.sv ====
////////////////////////////////////////////////////////////
// gain and offset calibration in two pipeline stages
// with saturation to the sample range
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_linear #(
  parameter int DW = `RP_SMP_W
) (
  input  logic         adc_clk,
  input  logic         top_rst,
  input  rp_pkg::smp_t smp_i,
  input  rp_pkg::mul_t mul_i,
  input  rp_pkg::sum_t sum_i,
  output rp_pkg::smp_t smp_o
);

  // full product plus one guard bit for the offset add
  localparam int PW = DW + `RP_MUL_W;
  localparam int AW = PW + 1;
  localparam logic signed [AW-1:0] SAT_MAX = AW'((2 ** (DW - 1)) - 1);
  localparam logic signed [AW-1:0] SAT_MIN = AW'(-(2 ** (DW - 1)));

  logic signed [PW-1:0] mul_q;
  logic signed [AW-1:0] acc;
  logic signed [DW-1:0] sat;

  // stage 1 registers the widened product
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      mul_q <= '0;
    end else begin
      mul_q <= PW'(smp_i) * PW'(mul_i);
    end
  end

  // drop fraction bits and add offset
  assign acc = AW'(mul_q >>> `RP_MUL_SHIFT) + AW'(sum_i);

  // clip to signed sample range
  always_comb begin
    if (acc > SAT_MAX) begin
      sat = SAT_MAX[DW-1:0];
    end else if (acc < SAT_MIN) begin
      sat = SAT_MIN[DW-1:0];
    end else begin
      sat = acc[DW-1:0];
    end
  end

  // stage 2
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else begin
      smp_o <= sat;
    end
  end

endmodule : rp_linear

`default_nettype wire

// ==== rtl/rp_adc_path.sv ====
////////////////////////////////////////////////////////////
// ADC channel: pin capture to signed, digital loopback
// mux and calibration
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_adc_path (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // ADC pins, offset binary
  input  logic [`RP_ADC_W-1:0]  adc_dat_i,
  // loopback from the DAC side
  input  logic                  loop_i,
  input  rp_pkg::smp_t          loop_smp_i,
  // calibration
  input  rp_pkg::mul_t          mul_i,
  input  rp_pkg::sum_t          sum_i,
  // calibrated sample
  output rp_pkg::smp_t          adc_smp_o
);

  import rp_pkg::*;

  smp_t adc_raw;
  smp_t lin_in;

  // pin capture
  // low two bits reserved, msb kept, rest inverted
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= {adc_dat_i[`RP_ADC_W-1],
                  ~adc_dat_i[`RP_ADC_W-2:`RP_ADC_W-`RP_SMP_W]};
    end
  end

  // digital loopback, no added register
  assign lin_in = loop_i ? loop_smp_i : adc_raw;

  // two-cycle calibration
  rp_linear u_lin (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (lin_in),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .smp_o   (adc_smp_o)
  );

endmodule : rp_adc_path

`default_nettype wire

// ==== rtl/rp_dac_path.sv ====
////////////////////////////////////////////////////////////
// DAC channel: source select, calibration and inverted
// slope unsigned output code
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_dac_path (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // source select, 1 takes the host stream
  input  logic                  host_i,
  input  rp_pkg::smp_t          gen_dat_i,
  input  rp_pkg::smp_t          host_dat_i,
  // calibration
  input  rp_pkg::mul_t          mul_i,
  input  rp_pkg::sum_t          sum_i,
  // signed sample toward the ADC loopback
  output rp_pkg::smp_t          cal_smp_o,
  // DAC code
  output logic [`RP_SMP_W-1:0]  dac_dat_o
);

  import rp_pkg::*;

  smp_t src_smp;

  // source mux
  assign src_smp = host_i ? host_dat_i : gen_dat_i;

  rp_linear u_lin (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (src_smp),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .smp_o   (cal_smp_o)
  );

  // output register
  // signed to unsigned with negative slope
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      // code for zero
      dac_dat_o <= {1'b0, {(`RP_SMP_W-1){1'b1}}};
    end else begin
      dac_dat_o <= {cal_smp_o[`RP_SMP_W-1], ~cal_smp_o[`RP_SMP_W-2:0]};
    end
  end

endmodule : rp_dac_path

`default_nettype wire

// ==== rtl/rp_debounce.sv ====
////////////////////////////////////////////////////////////
// input debouncer, hold-off FSM with edge pulses
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_debounce (
  input  logic         adc_clk,
  input  logic         top_rst,
  // hold-off length in cycles
  input  rp_pkg::len_t len_i,
  // raw asynchronous input
  input  logic         d_i,
  // stable level and edge pulses
  output logic         d_o,
  output logic         pos_o,
  output logic         neg_o
);

  import rp_pkg::*;

  logic [1:0] sync_q;
  deb_state_e state_q;
  len_t       cnt_q;

  // two-flop synchronizer
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], d_i};
    end
  end

  ////////////////////////////////////////////////////////////
  // hold-off FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state_q <= DEB_IDLE;
      cnt_q   <= '0;
      d_o     <= 1'b0;
      pos_o   <= 1'b0;
      neg_o   <= 1'b0;
    end else begin
      // pulses last one cycle
      pos_o <= 1'b0;
      neg_o <= 1'b0;
      case (state_q)
        DEB_IDLE: begin
          // level change, take it and start hold-off
          if (sync_q[1] != d_o) begin
            d_o     <= sync_q[1];
            pos_o   <= sync_q[1];
            neg_o   <= ~sync_q[1];
            cnt_q   <= len_i;
            state_q <= DEB_HOLD;
          end
        end
        DEB_HOLD: begin
          // input ignored until the count runs out
          if (cnt_q > len_t'(1)) begin
            cnt_q <= cnt_q - len_t'(1);
          end else begin
            state_q <= DEB_IDLE;
          end
        end
        default: state_q <= DEB_IDLE;
      endcase
    end
  end

endmodule : rp_debounce

`default_nettype wire

// ==== rtl/rp_top.sv ====
////////////////////////////////////////////////////////////
// analog core top: registers, ADC and DAC channel paths
// with loopback, expansion input debouncer
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_top (
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  // register access
  input  logic                                 reg_wr_i,
  input  logic                                 reg_rd_i,
  input  logic [`RP_ADDR_W-1:0]                reg_addr_i,
  input  logic [`RP_DATA_W-1:0]                reg_wdata_i,
  output logic [`RP_DATA_W-1:0]                reg_rdata_o,
  output logic                                 reg_ack_o,
  // ADC pins
  input  logic [`RP_CHN-1:0][`RP_ADC_W-1:0]    adc_dat_i,
  // DAC sample sources
  input  rp_pkg::smp_t [`RP_CHN-1:0]           gen_dat_i,
  input  rp_pkg::smp_t [`RP_CHN-1:0]           host_dat_i,
  // expansion input
  input  logic                                 exp_i,
  // outputs
  output rp_pkg::smp_t [`RP_CHN-1:0]           adc_smp_o,
  output logic [`RP_CHN-1:0][`RP_SMP_W-1:0]    dac_dat_o,
  output logic                                 deb_lvl_o,
  output logic                                 deb_pos_o,
  output logic                                 deb_neg_o
);

  import rp_pkg::*;

  // settings from the register block
  logic [`RP_CHN-1:0] mux_loop;
  logic [`RP_CHN-1:0] mux_host;
  mul_t [`RP_CHN-1:0] adc_mul;
  sum_t [`RP_CHN-1:0] adc_sum;
  mul_t [`RP_CHN-1:0] dac_mul;
  sum_t [`RP_CHN-1:0] dac_sum;
  len_t               deb_len;
  // calibrated DAC samples for loopback
  smp_t [`RP_CHN-1:0] dac_cal;

  rp_regs u_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .reg_wr_i    (reg_wr_i),
    .reg_rd_i    (reg_rd_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .mux_loop_o  (mux_loop),
    .mux_host_o  (mux_host),
    .adc_mul_o   (adc_mul),
    .adc_sum_o   (adc_sum),
    .dac_mul_o   (dac_mul),
    .dac_sum_o   (dac_sum),
    .deb_len_o   (deb_len)
  );

  ////////////////////////////////////////////////////////////
  // channel paths
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < `RP_CHN; ch++) begin : g_chn
    // loopback stays within the channel
    rp_adc_path u_adc (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .adc_dat_i  (adc_dat_i[ch]),
      .loop_i     (mux_loop[ch]),
      .loop_smp_i (dac_cal[ch]),
      .mul_i      (adc_mul[ch]),
      .sum_i      (adc_sum[ch]),
      .adc_smp_o  (adc_smp_o[ch])
    );

    rp_dac_path u_dac (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .host_i     (mux_host[ch]),
      .gen_dat_i  (gen_dat_i[ch]),
      .host_dat_i (host_dat_i[ch]),
      .mul_i      (dac_mul[ch]),
      .sum_i      (dac_sum[ch]),
      .cal_smp_o  (dac_cal[ch]),
      .dac_dat_o  (dac_dat_o[ch])
    );
  end : g_chn

  // expansion input events
  rp_debounce u_deb (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .len_i   (deb_len),
    .d_i     (exp_i),
    .d_o     (deb_lvl_o),
    .pos_o   (deb_pos_o),
    .neg_o   (deb_neg_o)
  );

endmodule : rp_top

`default_nettype wire

// ==== verif/rp_sva.sv ====
////////////////////////////////////////////////////////////
// assertions on register ack reset and debounce pulses
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rp_sva (
  input logic adc_clk,
  input logic top_rst,
  input logic reg_ack_o,
  input logic deb_pos_o,
  input logic deb_neg_o
);

  // ack stays low through reset and on release
  a_ack_rst: assert property (@(posedge adc_clk) top_rst |=> !reg_ack_o)
    else $error("reg_ack_o high after reset");

  // one direction at a time
  a_deb_excl: assert property (@(posedge adc_clk) disable iff (top_rst)
    !(deb_pos_o && deb_neg_o))
    else $error("debounce pulses high together");

  // single-cycle pulses
  a_pos_len: assert property (@(posedge adc_clk) disable iff (top_rst)
    deb_pos_o |=> !deb_pos_o)
    else $error("deb_pos_o longer than one cycle");

  a_neg_len: assert property (@(posedge adc_clk) disable iff (top_rst)
    deb_neg_o |=> !deb_neg_o)
    else $error("deb_neg_o longer than one cycle");

endmodule : rp_sva

bind rp_top rp_sva u_sva (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .reg_ack_o (reg_ack_o),
  .deb_pos_o (deb_pos_o),
  .deb_neg_o (deb_neg_o)
);

`default_nettype wire

// ==== verif/rp_tb.sv ====
////////////////////////////////////////////////////////////
// analog core testbench with random samples, register setup,
// reference model and per-cycle output compare
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_tb;

  import rp_pkg::*;

  localparam int          TMO  = 200;
  localparam logic [31:0] SEED = 32'h98a5_7d2a;

  logic                              adc_clk;
  logic                              top_rst;
  logic                              reg_wr_i;
  logic                              reg_rd_i;
  logic [`RP_ADDR_W-1:0]             reg_addr_i;
  logic [`RP_DATA_W-1:0]             reg_wdata_i;
  logic [`RP_DATA_W-1:0]             reg_rdata_o;
  logic                              reg_ack_o;
  logic [`RP_CHN-1:0][`RP_ADC_W-1:0] adc_dat_i;
  smp_t [`RP_CHN-1:0]                gen_dat_i;
  smp_t [`RP_CHN-1:0]                host_dat_i;
  logic                              exp_i;
  smp_t [`RP_CHN-1:0]                adc_smp_o;
  logic [`RP_CHN-1:0][`RP_SMP_W-1:0] dac_dat_o;
  logic                              deb_lvl_o;
  logic                              deb_pos_o;
  logic                              deb_neg_o;

  // expected register contents
  logic [`RP_CHN-1:0] sh_loop;
  logic [`RP_CHN-1:0] sh_host;
  mul_t               sh_adc_mul [`RP_CHN];
  sum_t               sh_adc_sum [`RP_CHN];
  mul_t               sh_dac_mul [`RP_CHN];
  sum_t               sh_dac_sum [`RP_CHN];

  // compare enable and delay lines with index 0 newest
  logic                 chk_en;
  smp_t                 exp_adc [`RP_CHN][4];
  logic [`RP_SMP_W-1:0] exp_dac [`RP_CHN][4];
  int                   pos_cnt;
  int                   neg_cnt;

  rp_top u_dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .reg_wr_i    (reg_wr_i),
    .reg_rd_i    (reg_rd_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .adc_dat_i   (adc_dat_i),
    .gen_dat_i   (gen_dat_i),
    .host_dat_i  (host_dat_i),
    .exp_i       (exp_i),
    .adc_smp_o   (adc_smp_o),
    .dac_dat_o   (dac_dat_o),
    .deb_lvl_o   (deb_lvl_o),
    .deb_pos_o   (deb_pos_o),
    .deb_neg_o   (deb_neg_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // gain with 13 fraction bits plus offset and clipping to 14 bits
  function automatic smp_t ref_linear(input smp_t smp, input mul_t mul, input sum_t sum);
    longint acc;
    acc = (longint'(smp) * longint'(mul)) >>> `RP_MUL_SHIFT;
    acc = acc + longint'(sum);
    if (acc > 64'sd8191) begin
      acc = 64'sd8191;
    end else if (acc < -64'sd8192) begin
      acc = -64'sd8192;
    end
    return acc[`RP_SMP_W-1:0];
  endfunction

  // pins 15:2 with msb kept and lower bits flipped
  function automatic smp_t adc_conv(input logic [`RP_ADC_W-1:0] pins);
    logic [`RP_SMP_W-1:0] raw;
    raw = pins[`RP_ADC_W-1:`RP_ADC_W-`RP_SMP_W];
    return raw ^ 14'h1fff;
  endfunction

  // inverted slope DAC code
  function automatic logic [`RP_SMP_W-1:0] dac_conv(input smp_t smp);
    return smp ^ 14'h1fff;
  endfunction

  // random sample with one in four at a range limit
  function automatic smp_t pick_smp();
    logic [31:0] r;
    r = $urandom();
    case (r[31:29])
      3'd0:    return 14'h2000;
      3'd1:    return 14'h1fff;
      default: return r[`RP_SMP_W-1:0];
    endcase
  endfunction

  function automatic logic [`RP_ADC_W-1:0] pick_pins();
    logic [31:0] r;
    r = $urandom();
    case (r[31:29])
      3'd0:    return 16'h0000;
      3'd1:    return 16'hffff;
      default: return r[`RP_ADC_W-1:0];
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_smp(input string name, input smp_t got, input smp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_dac(input string name, input logic [`RP_SMP_W-1:0] got,
                           input logic [`RP_SMP_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input logic [`RP_DATA_W-1:0] got,
                           input logic [`RP_DATA_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // register access
  ////////////////////////////////////////////////////////////

  task automatic reg_write(input logic [`RP_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge adc_clk);
    reg_wr_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge adc_clk);
    reg_wr_i    = 1'b0;
  endtask

  // strobe for one cycle and wait for the ack
  task automatic read_expect(input logic [`RP_ADDR_W-1:0] addr, input logic [31:0] exp);
    int n;
    @(negedge adc_clk);
    reg_rd_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge adc_clk);
    reg_rd_i   = 1'b0;
    n = 0;
    while (!reg_ack_o) begin
      if (n == TMO) abort_run("register read was never acknowledged");
      n++;
      @(negedge adc_clk);
    end
    check_reg($sformatf("reg_rdata_o at 0x%h", addr), reg_rdata_o, exp);
    // ack is a single-cycle pulse
    @(negedge adc_clk);
    check_bit("reg_ack_o", reg_ack_o, 1'b0);
  endtask

  task automatic set_cal(input int ch, input mul_t am, input sum_t as,
                         input mul_t dm, input sum_t ds);
    logic [`RP_ADDR_W-1:0] ofs;
    ofs = 4'(2 * ch);
    reg_write(4'(REG_ADC_MUL0) + ofs, 32'(am));
    reg_write(4'(REG_ADC_SUM0) + ofs, 32'(as));
    reg_write(4'(REG_DAC_MUL0) + ofs, 32'(dm));
    reg_write(4'(REG_DAC_SUM0) + ofs, 32'(ds));
    sh_adc_mul[ch] = am;
    sh_adc_sum[ch] = as;
    sh_dac_mul[ch] = dm;
    sh_dac_sum[ch] = ds;
    // gains and offsets come back sign-extended
    read_expect(4'(REG_ADC_MUL0) + ofs, 32'(am));
    read_expect(4'(REG_ADC_SUM0) + ofs, 32'(as));
    read_expect(4'(REG_DAC_MUL0) + ofs, 32'(dm));
    read_expect(4'(REG_DAC_SUM0) + ofs, 32'(ds));
  endtask

  task automatic random_cal(input int ch);
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = $urandom();
    r2 = $urandom();
    set_cal(ch, r1[15:0], r1[29:16], r2[15:0], r2[29:16]);
  endtask

  task automatic set_mux(input logic [1:0] loop, input logic [1:0] host);
    reg_write(REG_MUX, {28'd0, host, loop});
    sh_loop = loop;
    sh_host = host;
    read_expect(REG_MUX, {28'd0, host, loop});
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(negedge adc_clk);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic drive_samples();
    forever begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `RP_CHN; ch++) begin
        adc_dat_i[ch]  = pick_pins();
        gen_dat_i[ch]  = pick_smp();
        host_dat_i[ch] = pick_smp();
      end
    end
  endtask

  // pulse counters move on negedge and are read after a posedge
  task automatic wait_event(input logic rising, input int target);
    int n;
    n = 0;
    while ((rising ? pos_cnt : neg_cnt) < target) begin
      if (n == TMO) abort_run("expected debounce pulse never came");
      n++;
      @(posedge adc_clk);
    end
  endtask

  task automatic check_counts(input int exp_pos, input int exp_neg);
    @(posedge adc_clk);
    if (pos_cnt != exp_pos) abort_run("wrong number of rising debounce pulses");
    if (neg_cnt != exp_neg) abort_run("wrong number of falling debounce pulses");
  endtask

  initial begin : pulse_count
    pos_cnt = 0;
    neg_cnt = 0;
    forever begin
      @(negedge adc_clk);
      if (deb_pos_o) pos_cnt++;
      if (deb_neg_o) neg_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // per-cycle compare
  ////////////////////////////////////////////////////////////

  // inputs taken at posedge and outputs checked at the next negedge
  initial begin : compare
    smp_t cal;
    int   fill;
    logic do_cmp;
    int   tap [`RP_CHN];
    fill = 0;
    forever begin
      @(posedge adc_clk);
      if (chk_en) begin
        for (int ch = 0; ch < `RP_CHN; ch++) begin
          cal = ref_linear(sh_host[ch] ? host_dat_i[ch] : gen_dat_i[ch],
                           sh_dac_mul[ch], sh_dac_sum[ch]);
          for (int k = 3; k > 0; k--) begin
            exp_adc[ch][k] = exp_adc[ch][k-1];
            exp_dac[ch][k] = exp_dac[ch][k-1];
          end
          exp_dac[ch][0] = dac_conv(cal);
          if (sh_loop[ch]) begin
            exp_adc[ch][0] = ref_linear(cal, sh_adc_mul[ch], sh_adc_sum[ch]);
          end else begin
            exp_adc[ch][0] = ref_linear(adc_conv(adc_dat_i[ch]),
                                        sh_adc_mul[ch], sh_adc_sum[ch]);
          end
          // loopback adds the DAC calibration stages
          tap[ch] = sh_loop[ch] ? 3 : 2;
        end
        if (fill < 4) fill++;
      end else begin
        fill = 0;
      end
      do_cmp = (fill == 4);
      @(negedge adc_clk);
      if (do_cmp) begin
        for (int ch = 0; ch < `RP_CHN; ch++) begin
          check_smp($sformatf("adc_smp_o[%0d]", ch), adc_smp_o[ch], exp_adc[ch][tap[ch]]);
          check_dac($sformatf("dac_dat_o[%0d]", ch), dac_dat_o[ch], exp_dac[ch][2]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] r;
    void'($urandom(SEED));
    top_rst     = 1'b1;
    reg_wr_i    = 1'b0;
    reg_rd_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    adc_dat_i   = '0;
    gen_dat_i   = '0;
    host_dat_i  = '0;
    exp_i       = 1'b0;
    chk_en      = 1'b0;
    sh_loop     = '0;
    sh_host     = '0;
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      sh_adc_mul[ch] = 16'h2000;
      sh_dac_mul[ch] = 16'h2000;
      sh_adc_sum[ch] = '0;
      sh_dac_sum[ch] = '0;
    end
    fork
      drive_samples();
    join_none

    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    // outputs held at their reset values
    check_bit("reg_ack_o", reg_ack_o, 1'b0);
    check_bit("deb_pos_o", deb_pos_o, 1'b0);
    check_bit("deb_neg_o", deb_neg_o, 1'b0);
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      check_smp($sformatf("adc_smp_o[%0d]", ch), adc_smp_o[ch], 14'h0000);
      check_dac($sformatf("dac_dat_o[%0d]", ch), dac_dat_o[ch], 14'h1fff);
    end
    top_rst = 1'b0;

    // register reset values and unity pass-through
    read_expect(REG_MUX, 32'h0);
    read_expect(REG_DEB_LEN, 32'd62500);
    for (int a = 2; a < 10; a += 2) begin
      read_expect(4'(a), 32'h0000_2000);
      read_expect(4'(a + 1), 32'h0);
    end
    chk_en = 1'b1;
    run_cycles(50);

    // unmapped addresses
    chk_en = 1'b0;
    r = $urandom();
    reg_write(4'hc, r);
    read_expect(4'hc, 32'h0);
    read_expect(4'ha, 32'h0);
    read_expect(4'hf, 32'h0);
    read_expect(REG_MUX, 32'h0);

    // forced saturation in both directions
    set_cal(0, 16'h7fff, 14'h1fff, 16'h7fff, 14'h2000);
    set_cal(1, 16'h8000, 14'h2000, 16'h8000, 14'h1fff);
    chk_en = 1'b1;
    run_cycles(100);

    // random calibration rounds
    for (int i = 0; i < 3; i++) begin
      chk_en = 1'b0;
      random_cal(0);
      random_cal(1);
      chk_en = 1'b1;
      run_cycles(200);
    end

    // host source per channel and then loopback
    for (int m = 1; m < 4; m++) begin
      chk_en = 1'b0;
      set_mux(2'b00, 2'(m));
      chk_en = 1'b1;
      run_cycles(100);
    end
    for (int m = 1; m < 4; m++) begin
      chk_en = 1'b0;
      set_mux(2'(m), 2'(m + 1));
      chk_en = 1'b1;
      run_cycles(100);
    end

    // debounce with a short hold-off and glitches inside it
    reg_write(REG_DEB_LEN, 32'd16);
    read_expect(REG_DEB_LEN, 32'd16);
    @(negedge adc_clk);
    exp_i = 1'b1;
    wait_event(1'b1, 1);
    @(negedge adc_clk);
    check_bit("deb_lvl_o", deb_lvl_o, 1'b1);
    exp_i = 1'b0;
    @(negedge adc_clk);
    exp_i = 1'b1;
    run_cycles(60);
    check_counts(1, 0);
    @(negedge adc_clk);
    exp_i = 1'b0;
    wait_event(1'b0, 1);
    @(negedge adc_clk);
    check_bit("deb_lvl_o", deb_lvl_o, 1'b0);
    exp_i = 1'b1;
    run_cycles(2);
    exp_i = 1'b0;
    run_cycles(60);
    check_counts(1, 1);

    run_cycles(10);
    $display("TEST PASS");
    $finish;
  end

endmodule : rp_tb

`default_nettype wire

// ==== rp_top.f ====
+incdir+rtl
rtl/rp_pkg.sv
rtl/rp_regs.sv
rtl/rp_linear.sv
rtl/rp_adc_path.sv
rtl/rp_dac_path.sv
rtl/rp_debounce.sv
rtl/rp_top.sv
verif/rp_sva.sv
verif/rp_tb.sv

// ==== Makefile ====
# Verilator build and run for the analog core testbench

VERILATOR ?= verilator
TOP       ?= rp_tb
FLIST     ?= rp_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?=

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulation is the result
run: $(BIN)
	./$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
